// ==== filelist.f ====
src/lc3b_pkg.sv
src/alu.sv
src/regfile.sv
src/control.sv
src/datapath.sv
src/lc3b_cpu.sv
verification/tb_clock_gen.sv
verification/lc3b_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LC-3b core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module lc3b_cpu_tb -o lc3b_sim \
    && ./obj_dir/lc3b_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log && echo "Simulation ok" || { echo "Simulation failed"; exit 1; }

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  lc3b_pkg::lc3b_aluop aluop,
    input  lc3b_pkg::lc3b_word  a,
    input  lc3b_pkg::lc3b_word  b,
    output lc3b_pkg::lc3b_word  f
);

    always_comb begin
        case (aluop)
            lc3b_pkg::alu_add: f = a + b;
            lc3b_pkg::alu_and: f = a & b;
            lc3b_pkg::alu_not: f = ~a;
            lc3b_pkg::alu_pass: f = a;
            // Shift amount comes from the low nibble only
            lc3b_pkg::alu_sll: f = a << b[3:0];
            lc3b_pkg::alu_srl: f = a >> b[3:0];
            lc3b_pkg::alu_sra: f = $signed(a) >>> b[3:0];
            default: f = a;
        endcase
    end

endmodule : alu

// ==== src/control.sv ====
`timescale 1ns/1ps

module control (
    input  logic                     clk,
    input  logic                     reset,
    input  lc3b_pkg::lc3b_opcode     opcode,
    input  logic                     inst4,
    input  logic                     inst5,
    input  logic                     inst11,
    input  logic                     branch_enable,
    input  logic                     mar_lsb,
    input  logic                     mem_resp,
    output logic                     load_pc,
    output logic                     load_ir,
    output logic                     load_regfile,
    output logic                     load_mar,
    output logic                     load_mdr,
    output logic                     load_cc,
    output logic                     brmux_sel,
    output lc3b_pkg::pcmux_t         pcmux_sel,
    output logic                     storemux_sel,
    output logic                     destmux_sel,
    output lc3b_pkg::alumux_t        alumux_sel,
    output lc3b_pkg::regfilemux_t    regfilemux_sel,
    output lc3b_pkg::marmux_t        marmux_sel,
    output logic                     mdrmux_sel,
    output lc3b_pkg::lc3b_aluop      aluop,
    output logic                     mem_read,
    output logic                     mem_write,
    output lc3b_pkg::lc3b_mem_wmask  mem_byte_enable
);

    typedef enum logic [4:0] {
        s_fetch1, s_fetch2, s_fetch3, s_decode,
        s_add, s_and, s_not, s_shf,
        s_br, s_br_taken, s_jmp, s_jsr, s_lea,
        s_calc_addr_b, s_ldb1, s_ldb2, s_stb1, s_stb2,
        s_calc_addr_w, s_ldi1, s_ldi2, s_ldi3, s_ldi4,
        s_ldr1, s_ldr2, s_str1, s_str2
    } state_t;

    state_t state, next_state;

    always_comb begin : state_actions
        load_pc         = 1'b0;
        load_ir         = 1'b0;
        load_regfile    = 1'b0;
        load_mar        = 1'b0;
        load_mdr        = 1'b0;
        load_cc         = 1'b0;
        brmux_sel       = 1'b0;
        pcmux_sel       = lc3b_pkg::pcmux_plus2;
        storemux_sel    = 1'b0;
        destmux_sel     = 1'b0;
        alumux_sel      = lc3b_pkg::alumux_sr2;
        regfilemux_sel  = lc3b_pkg::regfilemux_alu;
        marmux_sel      = lc3b_pkg::marmux_alu;
        mdrmux_sel      = 1'b0;
        aluop           = lc3b_pkg::alu_add;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = 2'b11;

        case (state)
            s_fetch1: begin
                // MAR gets PC while PC steps to the next word
                marmux_sel = lc3b_pkg::marmux_pc;
                load_mar   = 1'b1;
                load_pc    = 1'b1;
            end
            // Every memory read lands in MDR
            s_fetch2, s_ldb1, s_ldi1, s_ldi3, s_ldr1: begin
                mem_read   = 1'b1;
                mdrmux_sel = 1'b1;
                load_mdr   = 1'b1;
            end
            s_fetch3: begin
                load_ir = 1'b1;
            end
            s_add, s_and: begin
                alumux_sel   = inst5 ? lc3b_pkg::alumux_imm5 : lc3b_pkg::alumux_sr2;
                aluop        = (state == s_and) ? lc3b_pkg::alu_and : lc3b_pkg::alu_add;
                load_cc      = 1'b1;
                load_regfile = 1'b1;
            end
            s_not: begin
                aluop        = lc3b_pkg::alu_not;
                load_cc      = 1'b1;
                load_regfile = 1'b1;
            end
            s_shf: begin
                alumux_sel = lc3b_pkg::alumux_imm4;
                if (!inst4) begin
                    aluop = lc3b_pkg::alu_sll;
                end else begin
                    aluop = inst5 ? lc3b_pkg::alu_sra : lc3b_pkg::alu_srl;
                end
                load_cc      = 1'b1;
                load_regfile = 1'b1;
            end
            s_br_taken: begin
                pcmux_sel = lc3b_pkg::pcmux_br;
                load_pc   = 1'b1;
            end
            s_jmp: begin
                pcmux_sel = lc3b_pkg::pcmux_sr1;
                load_pc   = 1'b1;
            end
            s_jsr: begin
                // Link into R7, then jump to base register or 11-bit offset
                regfilemux_sel = lc3b_pkg::regfilemux_pc;
                destmux_sel    = 1'b1;
                load_regfile   = 1'b1;
                brmux_sel      = 1'b1;
                pcmux_sel      = inst11 ? lc3b_pkg::pcmux_br : lc3b_pkg::pcmux_sr1;
                load_pc        = 1'b1;
            end
            s_lea: begin
                regfilemux_sel = lc3b_pkg::regfilemux_br;
                load_cc        = 1'b1;
                load_regfile   = 1'b1;
            end
            s_calc_addr_b: begin
                alumux_sel = lc3b_pkg::alumux_offset6;
                load_mar   = 1'b1;
            end
            s_ldb2: begin
                if (mar_lsb) begin
                    regfilemux_sel = lc3b_pkg::regfilemux_highbyte;
                end else begin
                    regfilemux_sel = lc3b_pkg::regfilemux_lowbyte;
                end
                load_cc      = 1'b1;
                load_regfile = 1'b1;
            end
            s_stb1: begin
                // Odd addresses move the byte into the upper lane
                storemux_sel = 1'b1;
                alumux_sel   = lc3b_pkg::alumux_eight;
                aluop        = mar_lsb ? lc3b_pkg::alu_sll : lc3b_pkg::alu_pass;
                load_mdr     = 1'b1;
            end
            s_stb2: begin
                mem_write       = 1'b1;
                mem_byte_enable = mar_lsb ? 2'b10 : 2'b01;
            end
            s_calc_addr_w: begin
                alumux_sel = lc3b_pkg::alumux_offset6_s1;
                load_mar   = 1'b1;
            end
            s_ldi2: begin
                marmux_sel = lc3b_pkg::marmux_mdr;
                load_mar   = 1'b1;
            end
            s_ldi4, s_ldr2: begin
                regfilemux_sel = lc3b_pkg::regfilemux_mdr;
                load_cc        = 1'b1;
                load_regfile   = 1'b1;
            end
            s_str1: begin
                storemux_sel = 1'b1;
                aluop        = lc3b_pkg::alu_pass;
                load_mdr     = 1'b1;
            end
            s_str2: begin
                mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin : next_state_logic
        next_state = state;
        case (state)
            s_fetch1: next_state = s_fetch2;
            s_fetch2: next_state = mem_resp ? s_fetch3 : s_fetch2;
            s_fetch3: next_state = s_decode;
            s_decode: begin
                case (opcode)
                    lc3b_pkg::op_add: next_state = s_add;
                    lc3b_pkg::op_and: next_state = s_and;
                    lc3b_pkg::op_not: next_state = s_not;
                    lc3b_pkg::op_shf: next_state = s_shf;
                    lc3b_pkg::op_br:  next_state = s_br;
                    lc3b_pkg::op_jmp: next_state = s_jmp;
                    lc3b_pkg::op_jsr: next_state = s_jsr;
                    lc3b_pkg::op_lea: next_state = s_lea;
                    lc3b_pkg::op_ldb, lc3b_pkg::op_stb: next_state = s_calc_addr_b;
                    lc3b_pkg::op_ldi, lc3b_pkg::op_ldr, lc3b_pkg::op_str: begin
                        next_state = s_calc_addr_w;
                    end
                    // Unsupported opcodes fall back to fetch
                    default: next_state = s_fetch1;
                endcase
            end
            s_br: next_state = branch_enable ? s_br_taken : s_fetch1;
            s_calc_addr_b: next_state = (opcode == lc3b_pkg::op_ldb) ? s_ldb1 : s_stb1;
            s_ldb1: next_state = mem_resp ? s_ldb2 : s_ldb1;
            s_stb1: next_state = s_stb2;
            s_calc_addr_w: begin
                if (opcode == lc3b_pkg::op_ldr) begin
                    next_state = s_ldr1;
                end else if (opcode == lc3b_pkg::op_str) begin
                    next_state = s_str1;
                end else begin
                    next_state = s_ldi1;
                end
            end
            s_ldi1: next_state = mem_resp ? s_ldi2 : s_ldi1;
            s_ldi2: next_state = s_ldi3;
            s_ldi3: next_state = mem_resp ? s_ldi4 : s_ldi3;
            s_ldr1: next_state = mem_resp ? s_ldr2 : s_ldr1;
            s_str1: next_state = s_str2;
            // Stores finish once memory answers
            s_stb2, s_str2: next_state = mem_resp ? s_fetch1 : state;
            default: next_state = s_fetch1;
        endcase
    end

    always_ff @(posedge clk) begin : next_state_assignment
        if (reset) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

    no_read_write_overlap: assert property (@(posedge clk) !(mem_read && mem_write));

    // Memory stays idle on the first cycle out of reset
    idle_after_reset: assert property (@(posedge clk) reset |=> !mem_read && !mem_write);

endmodule : control

// ==== src/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter lc3b_pkg::lc3b_word PC_RESET = 16'h0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_pc,
    input  logic                  load_ir,
    input  logic                  load_regfile,
    input  logic                  load_mar,
    input  logic                  load_mdr,
    input  logic                  load_cc,
    input  logic                  brmux_sel,
    input  lc3b_pkg::pcmux_t      pcmux_sel,
    input  logic                  storemux_sel,
    input  logic                  destmux_sel,
    input  lc3b_pkg::alumux_t     alumux_sel,
    input  lc3b_pkg::regfilemux_t regfilemux_sel,
    input  lc3b_pkg::marmux_t     marmux_sel,
    input  logic                  mdrmux_sel,
    input  lc3b_pkg::lc3b_aluop   aluop,
    input  lc3b_pkg::lc3b_word    mem_rdata,
    output lc3b_pkg::lc3b_opcode  opcode,
    output logic                  inst4,
    output logic                  inst5,
    output logic                  inst11,
    output logic                  branch_enable,
    output logic                  mar_lsb,
    output lc3b_pkg::lc3b_word    mem_address,
    output lc3b_pkg::lc3b_word    mem_wdata
);

    lc3b_pkg::lc3b_word pc, ir, mar, mdr;
    logic [2:0]         cc;
    lc3b_pkg::lc3b_reg  src_a, dest;
    lc3b_pkg::lc3b_word reg_a, reg_b, alu_b, alu_out;
    lc3b_pkg::lc3b_word br_offset, br_sum, rf_in;

    // Store and byte-store data come from the DR field
    assign src_a = storemux_sel ? ir[11:9] : ir[8:6];
    assign dest  = destmux_sel ? 3'd7 : ir[11:9];

    assign br_offset = brmux_sel ? {{4{ir[10]}}, ir[10:0], 1'b0} : {{6{ir[8]}}, ir[8:0], 1'b0};
    assign br_sum    = pc + br_offset;

    always_comb begin
        case (alumux_sel)
            lc3b_pkg::alumux_imm5:        alu_b = {{11{ir[4]}}, ir[4:0]};
            lc3b_pkg::alumux_offset6_s1:  alu_b = {{9{ir[5]}}, ir[5:0], 1'b0};
            lc3b_pkg::alumux_imm4:        alu_b = {12'h000, ir[3:0]};
            lc3b_pkg::alumux_offset6:     alu_b = {{10{ir[5]}}, ir[5:0]};
            lc3b_pkg::alumux_eight:       alu_b = 16'd8;
            default:                      alu_b = reg_b;
        endcase
        case (regfilemux_sel)
            lc3b_pkg::regfilemux_mdr:      rf_in = mdr;
            lc3b_pkg::regfilemux_br:       rf_in = br_sum;
            lc3b_pkg::regfilemux_pc:       rf_in = pc;
            lc3b_pkg::regfilemux_lowbyte:  rf_in = {{8{mdr[7]}}, mdr[7:0]};
            lc3b_pkg::regfilemux_highbyte: rf_in = {{8{mdr[15]}}, mdr[15:8]};
            default:                       rf_in = alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= PC_RESET;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            cc  <= 3'b010;
        end else begin
            if (load_pc) begin
                case (pcmux_sel)
                    lc3b_pkg::pcmux_br:  pc <= br_sum;
                    lc3b_pkg::pcmux_sr1: pc <= reg_a;
                    default:             pc <= pc + 16'd2;
                endcase
            end
            if (load_ir) begin
                ir <= mdr;
            end
            if (load_mar) begin
                case (marmux_sel)
                    lc3b_pkg::marmux_pc:  mar <= pc;
                    lc3b_pkg::marmux_mdr: mar <= mdr;
                    default:              mar <= alu_out;
                endcase
            end
            if (load_mdr) begin
                mdr <= mdrmux_sel ? mem_rdata : alu_out;
            end
            // NZP follows the value written back
            if (load_cc) begin
                cc <= {rf_in[15], rf_in == 16'h0000, !rf_in[15] && rf_in != 16'h0000};
            end
        end
    end

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .load  (load_regfile),
        .src_a (src_a),
        .src_b (ir[2:0]),
        .dest  (dest),
        .in    (rf_in),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    alu u_alu (
        .aluop (aluop),
        .a     (reg_a),
        .b     (alu_b),
        .f     (alu_out)
    );

    assign opcode        = lc3b_pkg::lc3b_opcode'(ir[15:12]);
    assign inst4         = ir[4];
    assign inst5         = ir[5];
    assign inst11        = ir[11];
    assign branch_enable = |(ir[11:9] & cc);
    assign mar_lsb       = mar[0];
    assign mem_address   = mar;
    assign mem_wdata     = mdr;

    // A read into MDR starts right after MAR is set or continues a pending read
    mdr_read_after_mar: assert property (@(posedge clk) disable iff (reset)
        (load_mdr && mdrmux_sel) |-> $past(load_mar) || $past(load_mdr && mdrmux_sel));

endmodule : datapath

// ==== src/lc3b_cpu.sv ====
`timescale 1ns/1ps

module lc3b_cpu #(
    parameter lc3b_pkg::lc3b_word PC_RESET = 16'h0000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  lc3b_pkg::lc3b_word      mem_rdata,
    input  logic                    mem_resp,
    output lc3b_pkg::lc3b_word      mem_address,
    output lc3b_pkg::lc3b_word      mem_wdata,
    output logic                    mem_read,
    output logic                    mem_write,
    output lc3b_pkg::lc3b_mem_wmask mem_byte_enable
);

    lc3b_pkg::lc3b_opcode  opcode;
    logic                  inst4, inst5, inst11, branch_enable, mar_lsb;
    logic                  load_pc, load_ir, load_regfile, load_mar, load_mdr, load_cc;
    logic                  brmux_sel, storemux_sel, destmux_sel, mdrmux_sel;
    lc3b_pkg::pcmux_t      pcmux_sel;
    lc3b_pkg::alumux_t     alumux_sel;
    lc3b_pkg::regfilemux_t regfilemux_sel;
    lc3b_pkg::marmux_t     marmux_sel;
    lc3b_pkg::lc3b_aluop   aluop;

    control u_control (
        .clk             (clk),
        .reset           (reset),
        .opcode          (opcode),
        .inst4           (inst4),
        .inst5           (inst5),
        .inst11          (inst11),
        .branch_enable   (branch_enable),
        .mar_lsb         (mar_lsb),
        .mem_resp        (mem_resp),
        .load_pc         (load_pc),
        .load_ir         (load_ir),
        .load_regfile    (load_regfile),
        .load_mar        (load_mar),
        .load_mdr        (load_mdr),
        .load_cc         (load_cc),
        .brmux_sel       (brmux_sel),
        .pcmux_sel       (pcmux_sel),
        .storemux_sel    (storemux_sel),
        .destmux_sel     (destmux_sel),
        .alumux_sel      (alumux_sel),
        .regfilemux_sel  (regfilemux_sel),
        .marmux_sel      (marmux_sel),
        .mdrmux_sel      (mdrmux_sel),
        .aluop           (aluop),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    datapath #(
        .PC_RESET (PC_RESET)
    ) u_datapath (
        .clk            (clk),
        .reset          (reset),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .brmux_sel      (brmux_sel),
        .pcmux_sel      (pcmux_sel),
        .storemux_sel   (storemux_sel),
        .destmux_sel    (destmux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_rdata      (mem_rdata),
        .opcode         (opcode),
        .inst4          (inst4),
        .inst5          (inst5),
        .inst11         (inst11),
        .branch_enable  (branch_enable),
        .mar_lsb        (mar_lsb),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata)
    );

endmodule : lc3b_cpu

// ==== src/lc3b_pkg.sv ====
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [1:0]  lc3b_mem_wmask;

    // Architectural LC-3b opcode encodings
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_ldb = 4'b0010,
        op_stb = 4'b0011,
        op_jsr = 4'b0100,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_ldi = 4'b1010,
        op_jmp = 4'b1100,
        op_shf = 4'b1101,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add, alu_and, alu_not, alu_pass, alu_sll, alu_srl, alu_sra
    } lc3b_aluop;

    typedef enum logic [1:0] {
        pcmux_plus2, pcmux_br, pcmux_sr1
    } pcmux_t;

    typedef enum logic [1:0] {
        marmux_alu, marmux_pc, marmux_mdr
    } marmux_t;

    // Second ALU operand
    typedef enum logic [2:0] {
        alumux_sr2, alumux_imm5, alumux_offset6_s1, alumux_imm4, alumux_offset6, alumux_eight
    } alumux_t;

    typedef enum logic [2:0] {
        regfilemux_alu, regfilemux_mdr, regfilemux_br, regfilemux_pc,
        regfilemux_lowbyte, regfilemux_highbyte
    } regfilemux_t;

endpackage : lc3b_pkg

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  lc3b_pkg::lc3b_reg  src_a,
    input  lc3b_pkg::lc3b_reg  src_b,
    input  lc3b_pkg::lc3b_reg  dest,
    input  lc3b_pkg::lc3b_word in,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);

    lc3b_pkg::lc3b_word data [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // Reads see the old value during a write cycle
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

endmodule : regfile

// ==== verification/lc3b_cpu_tb.sv ====
`timescale 1ns/1ps

module lc3b_cpu_tb;

    localparam lc3b_pkg::lc3b_word PC_RESET = 16'h0040;
    localparam int NUM_BLOCKS = 120;
    localparam int IDLE_LIMIT = 200;

    logic                    clk, reset, mem_resp, mem_read, mem_write;
    lc3b_pkg::lc3b_word      mem_rdata, mem_address, mem_wdata;
    lc3b_pkg::lc3b_mem_wmask mem_byte_enable;

    logic [7:0]         mem [65536];
    logic [7:0]         ref_mem [65536];
    lc3b_pkg::lc3b_word regs [8];
    logic [2:0]         ref_cc;
    // Expected access as {is_write, byte_enable, address, data}
    logic [34:0]        expected [$];
    lc3b_pkg::lc3b_word halt_addr;
    int                 errors, timeouts, idle_cycles, delay, accesses;
    logic               busy, done;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clock_gen (.clk(clk), .reset(reset));

    lc3b_cpu #(.PC_RESET(PC_RESET)) u_dut (
        .clk             (clk),
        .reset           (reset),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    task automatic compare(input lc3b_pkg::lc3b_word got, input lc3b_pkg::lc3b_word exp,
                           input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic lc3b_pkg::lc3b_word sext(input lc3b_pkg::lc3b_word v, input int bits);
        lc3b_pkg::lc3b_word m;
        m = 16'hffff << bits;
        return v[bits-1] ? (v | m) : (v & ~m);
    endfunction

    function automatic lc3b_pkg::lc3b_word ref_word(input lc3b_pkg::lc3b_word a);
        return {ref_mem[{a[15:1], 1'b1}], ref_mem[{a[15:1], 1'b0}]};
    endfunction

    task automatic put_word(input lc3b_pkg::lc3b_word a, input lc3b_pkg::lc3b_word w);
        mem[a]      = w[7:0];
        mem[a + 1]  = w[15:8];
    endtask

    task automatic set_reg(input logic [2:0] dr, input lc3b_pkg::lc3b_word v);
        regs[dr] = v;
        ref_cc   = {v[15], v == 16'h0000, !v[15] && v != 16'h0000};
    endtask

    // Program of four-word blocks whose control transfers land only on later block starts
    task automatic build_program();
        lc3b_pkg::lc3b_word b, t, off9;
        logic [2:0]         rd, rs;
        logic [5:0]         off;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
        end
        for (int a = 16'h7fc0; a < 16'h8100; a++) begin
            mem[a] = 8'($urandom);
        end
        // LDI pointer table below the data base
        for (int a = 16'h7fc0; a < 16'h8000; a += 2) begin
            put_word(16'(a), 16'h8000 + 16'(2 * $urandom_range(0, 31)));
        end
        halt_addr = PC_RESET + 16'(8 * (NUM_BLOCKS + 1));
        // R6 = 0x8000 through AND, ADD and a left shift by 15
        put_word(PC_RESET, 16'h5da0);
        put_word(PC_RESET + 2, 16'h1da1);
        put_word(PC_RESET + 4, 16'hdd8f);
        put_word(PC_RESET + 6, 16'h0000);
        for (int blk = 1; blk <= NUM_BLOCKS; blk++) begin
            b = PC_RESET + 16'(8 * blk);
            for (int i = 0; i < 8; i += 2) begin
                put_word(b + 16'(i), 16'h0000);
            end
            t    = PC_RESET + 16'(8 * ((blk + 3 > NUM_BLOCKS + 1) ? NUM_BLOCKS + 1
                                       : blk + $urandom_range(1, 3)));
            off9 = (t - b - 16'd2) >> 1;
            rd   = 3'($urandom_range(0, 5));
            rs   = 3'($urandom_range(0, 7));
            off  = 6'($urandom_range(0, 31));
            case ($urandom_range(0, 8))
                0: begin
                    case ($urandom_range(0, 3))
                        0: put_word(b, {4'b0001, rd, rs, 6'($urandom)});
                        1: put_word(b, {4'b0101, rd, rs, 6'($urandom)});
                        2: put_word(b, {4'b1001, rd, rs, 6'h3f});
                        default: put_word(b, {4'b1101, rd, rs, 6'($urandom)});
                    endcase
                    put_word(b + 2, {4'b0111, rd, 3'd6, off});
                end
                1: put_word(b, {4'b0000, 3'($urandom), off9[8:0]});
                2: begin
                    put_word(b, {4'b1110, rd, off9[8:0]});
                    put_word(b + 2, {4'b1100, 3'b000, rd, 6'b000000});
                end
                3: put_word(b, {4'b0100, 1'b1, off9[10:0]});
                4: begin
                    put_word(b, {4'b1110, rd, off9[8:0]});
                    put_word(b + 2, {4'b0100, 3'b000, rd, 6'b000000});
                end
                5: begin
                    put_word(b, {4'b0110, rd, 3'd6, off});
                    put_word(b + 2, {4'b0111, rd, 3'd6, 6'($urandom_range(0, 31))});
                end
                6: begin
                    put_word(b, {4'b1010, rd, 3'd6, 6'(-$urandom_range(1, 32))});
                    put_word(b + 2, {4'b0111, rd, 3'd6, off});
                end
                7: begin
                    put_word(b, {4'b0010, rd, 3'd6, off});
                    put_word(b + 2, {4'b0011, rd, 3'd6, 6'($urandom_range(0, 31))});
                end
                default: put_word(b, {4'b0111, rs, 3'd6, off});
            endcase
        end
        // Always-taken branch to itself
        put_word(halt_addr, 16'h0fff);
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = mem[a];
        end
    endtask

    // ISA model that records every memory access in program order
    task automatic run_model();
        lc3b_pkg::lc3b_word pc, ir, a, v;
        logic [2:0]         dr, sr;
        int                 steps;
        for (int i = 0; i < 8; i++) begin
            regs[i] = 16'h0000;
        end
        ref_cc = 3'b010;
        pc     = PC_RESET;
        steps  = 0;
        while (pc != halt_addr && steps < 5000) begin
            expected.push_back({1'b0, 2'b11, pc, 16'h0000});
            ir = ref_word(pc);
            pc = pc + 16'd2;
            dr = ir[11:9];
            sr = ir[8:6];
            a  = regs[sr] + sext(ir[5:0], 6);
            steps++;
            case (ir[15:12])
                4'b0001: set_reg(dr, regs[sr] + (ir[5] ? sext(ir[4:0], 5) : regs[ir[2:0]]));
                4'b0101: set_reg(dr, regs[sr] & (ir[5] ? sext(ir[4:0], 5) : regs[ir[2:0]]));
                4'b1001: set_reg(dr, ~regs[sr]);
                4'b1101: begin
                    if (!ir[4]) begin
                        set_reg(dr, regs[sr] << ir[3:0]);
                    end else if (ir[5]) begin
                        set_reg(dr, $signed(regs[sr]) >>> ir[3:0]);
                    end else begin
                        set_reg(dr, regs[sr] >> ir[3:0]);
                    end
                end
                4'b0000: begin
                    if ((ir[11:9] & ref_cc) != 3'b000) begin
                        pc = pc + (sext(ir[8:0], 9) << 1);
                    end
                end
                4'b1100: pc = regs[sr];
                4'b0100: begin
                    v  = pc;
                    pc = ir[11] ? pc + (sext(ir[10:0], 11) << 1) : regs[sr];
                    regs[7] = v;
                end
                4'b1110: set_reg(dr, pc + (sext(ir[8:0], 9) << 1));
                4'b0010: begin
                    expected.push_back({1'b0, 2'b11, a, 16'h0000});
                    set_reg(dr, sext({8'h00, ref_mem[a]}, 8));
                end
                4'b0011: begin
                    v = a[0] ? {regs[dr][7:0], 8'h00} : {8'h00, regs[dr][7:0]};
                    expected.push_back({1'b1, a[0] ? 2'b10 : 2'b01, a, v});
                    ref_mem[a] = regs[dr][7:0];
                end
                4'b0110, 4'b0111, 4'b1010: begin
                    a = regs[sr] + (sext(ir[5:0], 6) << 1);
                    if (ir[15:12] == 4'b0111) begin
                        expected.push_back({1'b1, 2'b11, a, regs[dr]});
                        ref_mem[a]     = regs[dr][7:0];
                        ref_mem[a + 1] = regs[dr][15:8];
                    end else begin
                        expected.push_back({1'b0, 2'b11, a, 16'h0000});
                        if (ir[15:12] == 4'b1010) begin
                            a = ref_word(a);
                            expected.push_back({1'b0, 2'b11, a, 16'h0000});
                        end
                        set_reg(dr, ref_word(a));
                    end
                end
                default: begin
                end
            endcase
        end
        expected.push_back({1'b0, 2'b11, halt_addr, 16'h0000});
    endtask

    task automatic check_access(input logic w, input logic [1:0] be,
                                input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word data);
        logic [34:0]        e;
        lc3b_pkg::lc3b_word lane;
        if (accesses == 0) begin
            compare(addr, PC_RESET, "first fetch address");
        end
        accesses++;
        if (done) begin
            return;
        end
        e = expected.pop_front();
        compare({15'h0, w}, {15'h0, e[34]}, "access kind");
        compare(addr, e[31:16], "access address");
        if (e[34]) begin
            compare({14'h0, be}, {14'h0, e[33:32]}, "byte enable");
            lane = {be[1] ? 8'hff : 8'h00, be[0] ? 8'hff : 8'h00};
            compare(data & lane, e[15:0] & lane, "store data");
        end
        if (expected.size() == 0) begin
            done = 1'b1;
        end
    endtask

    // Memory with a random 1 to 4 cycle response
    always @(posedge clk) begin
        compare({15'h0, mem_read && mem_write}, 16'h0000, "read and write overlap");
        if (reset) begin
            compare({15'h0, mem_read || mem_write}, 16'h0000, "memory strobe during reset");
            mem_resp    <= 1'b0;
            busy        = 1'b0;
            idle_cycles = 0;
        end else if (mem_resp) begin
            // Request still visible this edge belongs to the finished access
            mem_resp <= 1'b0;
            busy     = 1'b0;
        end else if (!busy && (mem_read || mem_write)) begin
            busy        = 1'b1;
            delay       = $urandom_range(1, 4);
            idle_cycles = 0;
            check_access(mem_write, mem_byte_enable, mem_address, mem_wdata);
        end else if (busy) begin
            delay--;
            if (delay == 0) begin
                if (mem_write) begin
                    if (mem_byte_enable[0]) begin
                        mem[{mem_address[15:1], 1'b0}] = mem_wdata[7:0];
                    end
                    if (mem_byte_enable[1]) begin
                        mem[{mem_address[15:1], 1'b1}] = mem_wdata[15:8];
                    end
                end
                mem_rdata <= {mem[{mem_address[15:1], 1'b1}], mem[{mem_address[15:1], 1'b0}]};
                mem_resp  <= 1'b1;
            end
        end else begin
            idle_cycles++;
        end
    end

    initial begin
        mem_resp  = 1'b0;
        mem_rdata = 16'h0000;
        errors    = 0;
        timeouts  = 0;
        accesses  = 0;
        busy      = 1'b0;
        done      = 1'b0;
        void'($urandom(33));
        build_program();
        run_model();
        for (int i = 0; i < 20 && reset; i++) begin
            @(negedge clk);
        end
        if (reset) begin
            $display("Reset was never released");
            timeouts++;
        end
        while (!done && timeouts == 0) begin
            @(negedge clk);
            if (idle_cycles > IDLE_LIMIT) begin
                $display("timeout waiting for memory request at %0t", $time);
                timeouts++;
            end
        end
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : lc3b_cpu_tb

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Synchronous reset released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule : tb_clock_gen
